// ==== sources.f ====
source/cx4_pkg.sv
source/cx4_host_decode.sv
source/cx4_dma_regs.sv
source/cx4_dma.sv
source/cx4_datram.sv
source/cx4_top.sv
verification/cx4_props.sv
verification/cx4_tb.sv

// ==== verification/cx4_tb.sv ====
`timescale 1ns/1ps

module cx4_tb;

  localparam int MAX_DMA_BYTES = 40 + 16 + 3 * 40;

  logic        CLK;
  logic        arst_n;
  logic [7:0]  DI;
  logic [7:0]  DO;
  logic [12:0] ADDR;
  logic        CS;
  logic        nWR;
  logic [7:0]  BUS_DI;
  logic [22:0] BUS_ADDR;
  logic        BUS_RRQ;
  logic        BUS_RDY;
  logic        cx4_active;

  logic [22:0] exp_q[$];   // expected bus addresses
  logic [22:0] obs_q[$];   // seen by the responder
  int          rdy_max;
  int          fail_count;

  cx4_top dut_i (
    .CLK (CLK), .arst_n (arst_n), .DI (DI), .DO (DO), .ADDR (ADDR), .CS (CS), .nWR (nWR),
    .BUS_DI (BUS_DI), .BUS_ADDR (BUS_ADDR), .BUS_RRQ (BUS_RRQ), .BUS_RDY (BUS_RDY),
    .cx4_active (cx4_active)
  );

  initial begin
    CLK = 1'b0;
    forever #2 CLK = ~CLK;
  end

  ////////////////////////////////////////////////////////////
  // reference model and reporting
  ////////////////////////////////////////////////////////////

  function automatic logic [22:0] map_src(input logic [23:0] s);
    return {s[23:16], s[14:0]};   // bit 15 dropped
  endfunction

  function automatic logic [7:0] bus_byte(input logic [22:0] a);
    return a[7:0] ^ a[15:8] ^ 8'h5a;
  endfunction

  task automatic report_mismatch(input string msg);
    fail_count++;
    $display("MISMATCH at %0t ns: %s", $time, msg);
    $display("CHECKS FAILED");
    $fatal(1);
  endtask

  task automatic report_failure(input string msg);
    fail_count++;
    $display("%s", msg);
    $display("CHECKS FAILED");
    $fatal(1);
  endtask

  task automatic check_byte(input logic [7:0] got, input logic [7:0] exp, input string what);
    assert (got === exp)
      else report_mismatch($sformatf("%s got %02h expected %02h", what, got, exp));
  endtask

  ////////////////////////////////////////////////////////////
  // host bus
  ////////////////////////////////////////////////////////////

  task automatic host_write(input logic [12:0] a, input logic [7:0] d);
    @(posedge CLK);
    ADDR <= a;
    DI   <= d;
    CS   <= 1'b1;
    nWR  <= 1'b0;
    repeat (6) @(posedge CLK);
    nWR <= 1'b1;
    repeat (3) @(posedge CLK);   // strobe lands on the last one
    CS <= 1'b0;
  endtask

  task automatic host_read(input logic [12:0] a, output logic [7:0] d);
    @(posedge CLK);
    ADDR <= a;
    CS   <= 1'b1;
    @(posedge CLK);
    @(negedge CLK);
    d = DO;   // RAM and register data one clock behind ADDR
    @(posedge CLK);
    CS <= 1'b0;
  endtask

  task automatic read_expect(input logic [12:0] a, input logic [7:0] exp);
    logic [7:0] d;
    host_read(a, d);
    check_byte(d, exp, $sformatf("read %04h", a));
  endtask

  task automatic wait_active(input logic level, input int limit);
    int n;
    n = 0;
    while (cx4_active !== level) begin
      @(posedge CLK);
      n++;
      if (n > limit) begin
        report_failure($sformatf("timeout waiting for cx4_active to become %0b", level));
      end
    end
  endtask

  ////////////////////////////////////////////////////////////
  // bus responder and address compare
  ////////////////////////////////////////////////////////////

  initial begin : responder
    logic [22:0] a;
    int          d;
    forever begin
      @(posedge CLK);
      if (BUS_RRQ === 1'b1) begin
        a = BUS_ADDR;
        obs_q.push_back(a);
        d = $urandom_range(rdy_max, 1);
        repeat (d) @(posedge CLK);   // back-pressure
        BUS_RDY <= 1'b1;
        BUS_DI  <= bus_byte(a);
        @(posedge CLK);
        BUS_RDY <= 1'b0;
      end
    end
  end

  initial begin : addr_compare
    logic [22:0] got;
    forever begin
      @(negedge CLK);
      while (obs_q.size() > 0) begin
        got = obs_q.pop_front();
        if (exp_q.size() == 0) begin
          report_failure($sformatf("unexpected bus request at address %06h", got));
        end
        assert (got === exp_q[0])
          else report_mismatch($sformatf("BUS_ADDR %06h expected %06h", got, exp_q[0]));
        void'(exp_q.pop_front());
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // DMA run with result check
  ////////////////////////////////////////////////////////////

  task automatic run_dma(input logic [23:0] src, input int len, input logic [11:0] tgt,
                         input int delay_max, input bit check_status);
    logic [7:0] hi;
    hi = 8'h30 + 8'(delay_max);
    rdy_max = delay_max;
    host_write(13'h0000 + tgt - 1, 8'hc3);   // guard bytes around the block
    host_write(13'h0000 + tgt + len, 8'h3c);
    for (int i = 0; i < len; i++) begin
      exp_q.push_back(map_src(src + 24'(i)));
    end
    host_write(13'h1f40, src[7:0]);
    host_write(13'h1f41, src[15:8]);
    host_write(13'h1f42, src[23:16]);
    host_write(13'h1f43, 8'(len));
    host_write(13'h1f44, 8'(len >> 8));
    host_write(13'h1f45, tgt[7:0]);
    host_write(13'h1f46, {4'h0, tgt[11:8]});
    host_write(13'h1f47, hi);
    wait_active(1'b1, 20);
    if (check_status) begin
      read_expect(13'h1f53, 8'h40);
      check_byte({7'd0, cx4_active}, 8'h01, "cx4_active during DMA");
    end
    wait_active(1'b0, len * 12 + 50);
    repeat (2) @(posedge CLK);
    if (exp_q.size() != 0) begin
      report_failure($sformatf("%0d bus requests missing", exp_q.size()));
    end
    for (int i = 0; i < len; i++) begin
      read_expect(13'h0000 + tgt + i, bus_byte(map_src(src + 24'(i))));
    end
    read_expect(13'h0000 + tgt - 1, 8'hc3);
    read_expect(13'h0000 + tgt + len, 8'h3c);
    if (check_status) begin
      read_expect(13'h1f5f, 8'h02);
      read_expect(13'h1f47, hi);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////

  initial begin : main
    logic [11:0] a;
    logic [7:0]  d;
    logic [7:0]  regs [7];
    int          len;
    void'($urandom(29));
    fail_count = 0;
    rdy_max    = 1;
    arst_n  <= 1'b0;
    DI      <= 8'h00;
    ADDR    <= '0;
    CS      <= 1'b0;
    nWR     <= 1'b1;
    BUS_DI  <= 8'h00;
    BUS_RDY <= 1'b0;
    repeat (5) @(posedge CLK);
    arst_n <= 1'b1;
    repeat (2) @(posedge CLK);
    // idle status
    read_expect(13'h1f53, 8'h02);
    check_byte({6'd0, cx4_active, BUS_RRQ}, 8'h00, "cx4_active and BUS_RRQ after reset");
    // host RAM access and unmapped holes
    for (int i = 0; i < 12; i++) begin
      a = 12'($urandom_range(12'hbff, 0));
      d = 8'($urandom);
      host_write({1'b0, a}, d);
      read_expect({1'b0, a}, d);
    end
    read_expect(13'h0c00, 8'h00);
    read_expect(13'h0fff, 8'h00);
    read_expect(13'h1f60, 8'h00);
    // register readback
    for (int i = 0; i < 7; i++) begin
      regs[i] = 8'($urandom);
      host_write(13'h1f40 + 13'(i), regs[i]);
    end
    for (int i = 0; i < 7; i++) begin
      read_expect(13'h1f40 + 13'(i), regs[i]);
    end
    for (int i = 8'h48; i <= 8'h52; i++) begin
      read_expect(13'h1f00 + 13'(i), 8'hff);
    end
    // single random DMA, then one with status checks
    len = $urandom_range(40, 1);
    run_dma(24'($urandom), len, 12'($urandom_range(12'hbff - len - 1, 1)), 5, 1'b0);
    run_dma(24'($urandom), 16, 12'h400, 3, 1'b1);
    // back-to-back with different back-pressure
    for (int k = 0; k < 3; k++) begin
      len = $urandom_range(40, 1);
      run_dma(24'($urandom), len, 12'($urandom_range(12'hbff - len - 1, 1)), 1 + 2 * k, 1'b0);
    end
    if (fail_count == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

  initial begin : watchdog
    repeat (MAX_DMA_BYTES * 12 + 2000) @(posedge CLK);
    $display("timeout: the test sequence did not finish in time");
    $display("CHECKS FAILED");
    $fatal(1);
  end

endmodule

// ==== verification/cx4_props.sv ====
`timescale 1ns/1ps

module cx4_dma_props (
  input logic                CLK,
  input logic                arst_n,
  input logic                BUS_RRQ,
  input logic                busy,
  input logic                ram_we,
  input cx4_pkg::dma_state_t state
);

  ////////////////////////////////////////////////////////////
  // bus request and RAM write rules
  ////////////////////////////////////////////////////////////

  rrq_single_pulse: assert property (@(posedge CLK) disable iff (!arst_n)
    BUS_RRQ |=> !BUS_RRQ)
    else $error("BUS_RRQ held high for two cycles");

  rrq_only_busy: assert property (@(posedge CLK) disable iff (!arst_n)
    BUS_RRQ |-> busy)
    else $error("BUS_RRQ raised while not busy");

  we_only_busy: assert property (@(posedge CLK) disable iff (!arst_n)
    ram_we |-> busy)
    else $error("RAM write while not busy");

  idle_not_busy: assert property (@(posedge CLK) disable iff (!arst_n)
    (state == cx4_pkg::dma_idle) |-> !busy)
    else $error("busy high in idle state");

endmodule

bind cx4_dma cx4_dma_props props_i (
  .CLK     (CLK),
  .arst_n  (arst_n),
  .BUS_RRQ (BUS_RRQ),
  .busy    (busy),
  .ram_we  (ram_we),
  .state   (state)
);

// ==== source/cx4_top.sv ====
`timescale 1ns/1ps

module cx4_top #(
  parameter int DATRAM_DEPTH = 3072,
  parameter int WR_SYNC_LEN  = 5
) (
  input  logic                            CLK,
  input  logic                            arst_n,
  // host side
  input  logic [7:0]                      DI,
  output logic [7:0]                      DO,
  input  logic [cx4_pkg::host_addr_w-1:0] ADDR,
  input  logic                            CS,
  input  logic                            nWR,
  // external bus
  input  logic [7:0]                      BUS_DI,
  output logic [cx4_pkg::bus_addr_w-1:0]  BUS_ADDR,
  output logic                            BUS_RRQ,
  input  logic                            BUS_RDY,
  output logic                            cx4_active
);

  cx4_pkg::host_wr_t                 wr;
  cx4_pkg::host_sel_t                sel;
  cx4_pkg::dma_cfg_t                 cfg;
  logic                              dma_start;
  logic                              dma_busy;
  logic [7:0]                        ram_rdata;
  logic [7:0]                        mmio_rdata;
  logic                              host_ram_we;
  logic                              dma_ram_we;
  logic [cx4_pkg::datram_addr_w-1:0] dma_ram_addr;
  logic [7:0]                        dma_ram_wdata;

  assign host_ram_we = wr.strobe & sel.datram;
  assign cx4_active  = dma_busy;

  ////////////////////////////////////////////////////////////
  // host interface and registers
  ////////////////////////////////////////////////////////////

  cx4_host_decode #(
    .WR_SYNC_LEN (WR_SYNC_LEN)
  ) host_decode_i (
    .CLK        (CLK),
    .arst_n     (arst_n),
    .DI         (DI),
    .ADDR       (ADDR),
    .CS         (CS),
    .nWR        (nWR),
    .ram_rdata  (ram_rdata),
    .mmio_rdata (mmio_rdata),
    .busy       (dma_busy),
    .wr         (wr),
    .sel        (sel),
    .DO         (DO)
  );

  cx4_dma_regs dma_regs_i (
    .CLK      (CLK),
    .arst_n   (arst_n),
    .wr       (wr),
    .mmio_sel (sel.mmio),   // only the 1f40 window writes here
    .cfg      (cfg),
    .start    (dma_start),
    .rdata    (mmio_rdata)
  );

  ////////////////////////////////////////////////////////////
  // DMA engine and data RAM
  ////////////////////////////////////////////////////////////

  cx4_dma dma_i (
    .CLK       (CLK),
    .arst_n    (arst_n),
    .start     (dma_start),
    .cfg       (cfg),
    .BUS_DI    (BUS_DI),
    .BUS_RDY   (BUS_RDY),
    .BUS_ADDR  (BUS_ADDR),
    .BUS_RRQ   (BUS_RRQ),
    .busy      (dma_busy),
    .ram_we    (dma_ram_we),
    .ram_addr  (dma_ram_addr),
    .ram_wdata (dma_ram_wdata)
  );

  cx4_datram #(
    .DEPTH (DATRAM_DEPTH)
  ) datram_i (
    .CLK     (CLK),
    .a_we    (host_ram_we),
    .a_addr  (wr.addr[cx4_pkg::datram_addr_w-1:0]),
    .a_wdata (wr.data),
    .b_we    (dma_ram_we),
    .b_addr  (dma_ram_addr),
    .b_wdata (dma_ram_wdata),
    .a_rdata (ram_rdata)
  );

endmodule

// ==== source/cx4_datram.sv ====
`timescale 1ns/1ps

module cx4_datram #(
  parameter int DEPTH = 3072
) (
  input  logic                              CLK,
  input  logic                              a_we,
  input  logic [cx4_pkg::datram_addr_w-1:0] a_addr,
  input  logic [7:0]                        a_wdata,
  input  logic                              b_we,
  input  logic [cx4_pkg::datram_addr_w-1:0] b_addr,
  input  logic [7:0]                        b_wdata,
  output logic [7:0]                        a_rdata
);

  logic [7:0] mem [DEPTH];

  ////////////////////////////////////////////////////////////
  // both write ports
  ////////////////////////////////////////////////////////////

  // same address on both ports: the DMA byte lands last
  always_ff @(posedge CLK) begin
    if (a_we) begin
      mem[a_addr] <= a_wdata;
    end
    if (b_we) begin
      mem[b_addr] <= b_wdata;
    end
  end

  // host read port, one cycle latency
  always_ff @(posedge CLK) begin
    a_rdata <= mem[a_addr];
  end

endmodule

// ==== source/cx4_dma.sv ====
`timescale 1ns/1ps

module cx4_dma (
  input  logic                              CLK,
  input  logic                              arst_n,
  input  logic                              start,
  input  cx4_pkg::dma_cfg_t                 cfg,
  input  logic [7:0]                        BUS_DI,
  input  logic                              BUS_RDY,
  output logic [cx4_pkg::bus_addr_w-1:0]    BUS_ADDR,
  output logic                              BUS_RRQ,
  output logic                              busy,
  output logic                              ram_we,
  output logic [cx4_pkg::datram_addr_w-1:0] ram_addr,
  output logic [7:0]                        ram_wdata
);

  cx4_pkg::dma_state_t state;
  logic [23:0]         src_addr;
  logic [15:0]         count;    // bytes still to fetch
  logic                take;

  // ready is not looked at in the request cycle
  assign take = (state == cx4_pkg::dma_wait) & ~BUS_RRQ & BUS_RDY;

  assign BUS_ADDR = {src_addr[23:16], src_addr[14:0]};

  ////////////////////////////////////////////////////////////
  // copy FSM
  ////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      state    <= cx4_pkg::dma_idle;
      src_addr <= '0;
      ram_addr <= '0;
      count    <= '0;
      busy     <= 1'b0;
      BUS_RRQ  <= 1'b0;
      ram_we   <= 1'b0;
    end else begin
      case (state)
        cx4_pkg::dma_idle: begin
          if (start) begin
            state <= cx4_pkg::dma_start;
          end
        end
        cx4_pkg::dma_start: begin
          busy     <= 1'b1;
          src_addr <= cfg.src;
          ram_addr <= cfg.tgt;
          count    <= cfg.len;
          BUS_RRQ  <= 1'b1;   // first byte
          state    <= cx4_pkg::dma_wait;
        end
        cx4_pkg::dma_wait: begin
          BUS_RRQ <= 1'b0;
          if (take) begin
            ram_we <= 1'b1;
            count  <= count - 16'd1;
            state  <= cx4_pkg::dma_addr;
          end
        end
        cx4_pkg::dma_addr: begin
          ram_we   <= 1'b0;
          src_addr <= src_addr + 24'd1;
          ram_addr <= ram_addr + 1'b1;
          if (count == 16'h0000) begin
            busy  <= 1'b0;
            state <= cx4_pkg::dma_idle;
          end else begin
            BUS_RRQ <= 1'b1;
            state   <= cx4_pkg::dma_wait;
          end
        end
        default: state <= cx4_pkg::dma_idle;
      endcase
    end
  end

  // hold the byte, BUS_DI is only valid while ready is up
  always_ff @(posedge CLK) begin
    if (take) begin
      ram_wdata <= BUS_DI;
    end
  end

endmodule

// ==== source/cx4_dma_regs.sv ====
`timescale 1ns/1ps

module cx4_dma_regs (
  input  logic              CLK,
  input  logic              arst_n,
  input  cx4_pkg::host_wr_t wr,
  input  logic              mmio_sel,
  output cx4_pkg::dma_cfg_t cfg,
  output logic              start,
  output logic [7:0]        rdata
);

  logic [23:0] src_r;
  logic [15:0] len_r;
  logic [23:0] tgt_r;     // full byte image for readback
  logic        reg_we;
  logic [4:0]  offset;

  assign offset = wr.addr[4:0];
  assign reg_we = wr.strobe & mmio_sel;

  ////////////////////////////////////////////////////////////
  // register writes
  ////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      src_r <= '0;
      len_r <= '0;
      tgt_r <= '0;
      start <= 1'b0;
    end else begin
      start <= 1'b0;
      if (reg_we) begin
        case (offset)
          5'h00: src_r[7:0]   <= wr.data;   // 1f40
          5'h01: src_r[15:8]  <= wr.data;
          5'h02: src_r[23:16] <= wr.data;
          5'h03: len_r[7:0]   <= wr.data;   // 1f43
          5'h04: len_r[15:8]  <= wr.data;
          5'h05: tgt_r[7:0]   <= wr.data;   // 1f45
          5'h06: tgt_r[15:8]  <= wr.data;
          5'h07: begin
            tgt_r[23:16] <= wr.data;   // 1f47 kicks off the copy
            start        <= 1'b1;
          end
          default: ;   // cache and cpu registers not present
        endcase
      end
    end
  end

  assign cfg.src = src_r;
  assign cfg.len = len_r;
  assign cfg.tgt = tgt_r[cx4_pkg::datram_addr_w-1:0];   // RAM is 12 bits deep

  ////////////////////////////////////////////////////////////
  // readback
  ////////////////////////////////////////////////////////////

  always_ff @(posedge CLK) begin
    case (offset)
      5'h00:   rdata <= src_r[7:0];
      5'h01:   rdata <= src_r[15:8];
      5'h02:   rdata <= src_r[23:16];
      5'h03:   rdata <= len_r[7:0];
      5'h04:   rdata <= len_r[15:8];
      5'h05:   rdata <= tgt_r[7:0];
      5'h06:   rdata <= tgt_r[15:8];
      5'h07:   rdata <= tgt_r[23:16];
      default: rdata <= 8'hff;   // 1f48..1f52 read as ff
    endcase
  end

endmodule

// ==== source/cx4_host_decode.sv ====
`timescale 1ns/1ps

module cx4_host_decode #(
  parameter int WR_SYNC_LEN = 5
) (
  input  logic                            CLK,
  input  logic                            arst_n,
  input  logic [7:0]                      DI,
  input  logic [cx4_pkg::host_addr_w-1:0] ADDR,
  input  logic                            CS,
  input  logic                            nWR,
  input  logic [7:0]                      ram_rdata,
  input  logic [7:0]                      mmio_rdata,
  input  logic                            busy,
  output cx4_pkg::host_wr_t               wr,
  output cx4_pkg::host_sel_t              sel,
  output logic [7:0]                      DO
);

  logic [WR_SYNC_LEN:0] nwr_sreg;    // bit 0 is the newest sample
  logic                 wr_edge;
  logic                 strobe_r;
  logic [7:0]           di_r;
  logic                 in_page;
  logic [7:0]           status_byte;

  ////////////////////////////////////////////////////////////
  // window decode
  ////////////////////////////////////////////////////////////

  assign in_page = (ADDR[12:5] == cx4_pkg::mmio_page);

  assign sel.datram = CS & (ADDR[11:0] < cx4_pkg::datram_limit);
  assign sel.mmio   = CS & in_page & (ADDR[4:0] < cx4_pkg::mmio_last);
  assign sel.status = CS & in_page & (ADDR[4:0] >= cx4_pkg::mmio_last);

  ////////////////////////////////////////////////////////////
  // write strobe
  ////////////////////////////////////////////////////////////

  // low for WR_SYNC_LEN samples, then high
  assign wr_edge = (nwr_sreg == {{WR_SYNC_LEN{1'b0}}, 1'b1});

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      nwr_sreg <= '1;   // bus idles with nWR high
      strobe_r <= 1'b0;
    end else begin
      nwr_sreg <= {nwr_sreg[WR_SYNC_LEN-1:0], nWR};
      strobe_r <= wr_edge;
    end
  end

  always_ff @(posedge CLK) begin
    di_r <= DI;
  end

  assign wr = '{addr: ADDR, data: di_r, strobe: strobe_r};

  ////////////////////////////////////////////////////////////
  // read data
  ////////////////////////////////////////////////////////////

  assign status_byte = {1'b0, busy, 4'b0000, ~busy, 1'b0};

  always_comb begin
    if (sel.datram) begin
      DO = ram_rdata;
    end else if (sel.mmio) begin
      DO = mmio_rdata;
    end else if (sel.status) begin
      DO = status_byte;
    end else begin
      DO = 8'h00;   // nothing mapped here
    end
  end

endmodule

// ==== source/cx4_pkg.sv ====
package cx4_pkg;

  ////////////////////////////////////////////////////////////
  // widths
  ////////////////////////////////////////////////////////////

  localparam int host_addr_w   = 13;
  localparam int datram_addr_w = 12;
  localparam int bus_addr_w    = 23;   // bit 15 of the source is dropped

  ////////////////////////////////////////////////////////////
  // host address map
  ////////////////////////////////////////////////////////////

  localparam logic [7:0]  mmio_page    = 8'hfa;   // 0x1f40..0x1f5f
  localparam logic [4:0]  mmio_last    = 5'h13;   // status starts at 0x1f53
  localparam logic [11:0] datram_limit = 12'hc00;

  ////////////////////////////////////////////////////////////
  // bundles
  ////////////////////////////////////////////////////////////

  typedef struct packed {
    logic [23:0]              src;
    logic [15:0]              len;
    logic [datram_addr_w-1:0] tgt;
  } dma_cfg_t;

  typedef struct packed {
    logic [host_addr_w-1:0] addr;
    logic [7:0]             data;     // DI, one cycle late
    logic                   strobe;
  } host_wr_t;

  typedef struct packed {
    logic datram;
    logic mmio;
    logic status;
  } host_sel_t;

  typedef enum logic [1:0] {
    dma_idle,
    dma_start,
    dma_wait,
    dma_addr
  } dma_state_t;

endpackage
